/* src/ip2_pkg.sv */
// Shared command, configuration and pin structs, status bit map, test constants and sizes
`default_nettype none

package ip2_pkg;

  // ---------------------------------------------------------------------
  // Sizes and test constants
  // ---------------------------------------------------------------------
  localparam int DEF_SCAN_BITS   = 64;             // Scan chain length in bits
  localparam int DEF_ARRAY_DEPTH = 16;             // 16-bit words in the config array

  localparam logic [3:0] TEST_SCAN      = 4'd1;    // Only test number still served
  localparam logic [5:0] MIN_TEST_DELAY = 6'd3;    // Shortest start delay accepted

  // Status word bit positions
  localparam int ST_W_STATIC = 0;
  localparam int ST_R_STATIC = 1;
  localparam int ST_W_ARRAY  = 2;
  localparam int ST_R_ARRAY  = 3;
  localparam int ST_R_DATA   = 4;
  localparam int ST_EXECUTE  = 5;
  localparam int ST_DONE     = 14;                 // Test 1 finished
  localparam int ST_ERROR    = 31;                 // Rejected execute word

  // ---------------------------------------------------------------------
  // Structs
  // ---------------------------------------------------------------------
  // Decoded op, strobes already gated by the device enable
  typedef struct packed {
    logic        w_static;
    logic        r_static;
    logic        w_array;
    logic        r_array;
    logic        r_data;
    logic        w_status_clear;
    logic        w_execute;
    logic [7:0]  addr;                             // Write word bits 23:16
    logic [23:0] data;                             // Whole write word
  } op_cmd_t;

  // Static register layout, MSB first
  typedef struct packed {
    logic [10:0] spare_hi;                         // Bits 23:13
    logic        super_pixel_sel;                  // Bit 12
    logic [5:0]  spare_lo;                         // Bits 11:6
    logic [5:0]  bit_period;                       // Scan bit length in clock cycles
  } static_cfg_t;

  // Execute word layout
  typedef struct packed {
    logic        mask_reset_not;                   // Skip the chip reset pulse
    logic [5:0]  spare;
    logic        loopback;                         // Capture scan_in instead of scan_out
    logic [3:0]  test_number;
    logic [5:0]  test_sample;                      // Sample phase inside a bit
    logic [5:0]  test_delay;                       // Cycles before the run starts
  } exec_cfg_t;

  // Chip pins driven by the test
  typedef struct packed {
    logic reset_not;
    logic scan_in;
    logic scan_load;
    logic super_pixel_sel;
  } pins_t;

endpackage

`default_nettype wire

/* src/ip2_op_decode.sv */
// Op strobe gating with the device enable and command register
`timescale 1ns/1ps
`default_nettype none

module ip2_op_decode (
  input  logic             fw_axi_clk,
  input  logic             op_code_w_reset,
  input  logic             fw_dev_id_enable,      // This board is addressed
  input  logic             fw_op_code_w_static,
  input  logic             fw_op_code_r_static,
  input  logic             fw_op_code_w_array,
  input  logic             fw_op_code_r_array,
  input  logic             fw_op_code_r_data,
  input  logic             fw_op_code_w_status_clear,
  input  logic             fw_op_code_w_execute,
  input  logic [23:0]      sw_write24_0,          // Write word from software
  output ip2_pkg::op_cmd_t op_cmd
);

  // One register stage, strobes and word stay aligned
  always_ff @(posedge fw_axi_clk) begin
    op_cmd.addr <= sw_write24_0[23:16];           // Address byte
    op_cmd.data <= sw_write24_0;
    if (op_code_w_reset) begin
      op_cmd.w_static       <= 1'b0;
      op_cmd.r_static       <= 1'b0;
      op_cmd.w_array        <= 1'b0;
      op_cmd.r_array        <= 1'b0;
      op_cmd.r_data         <= 1'b0;
      op_cmd.w_status_clear <= 1'b0;
      op_cmd.w_execute      <= 1'b0;
    end else begin
      // Other boards on the port see the same strobes
      op_cmd.w_static       <= fw_dev_id_enable & fw_op_code_w_static;
      op_cmd.r_static       <= fw_dev_id_enable & fw_op_code_r_static;
      op_cmd.w_array        <= fw_dev_id_enable & fw_op_code_w_array;
      op_cmd.r_array        <= fw_dev_id_enable & fw_op_code_r_array;
      op_cmd.r_data         <= fw_dev_id_enable & fw_op_code_r_data;
      op_cmd.w_status_clear <= fw_dev_id_enable & fw_op_code_w_status_clear;
      op_cmd.w_execute      <= fw_dev_id_enable & fw_op_code_w_execute;
    end
  end

endmodule

`default_nettype wire

/* src/ip2_cfg_regs.sv */
// Static configuration register and scan data array with their write ops
`timescale 1ns/1ps
`default_nettype none

module ip2_cfg_regs #(
  parameter int ARRAY_DEPTH = ip2_pkg::DEF_ARRAY_DEPTH
) (
  input  logic                         fw_axi_clk,
  input  logic                         op_code_w_reset,
  input  ip2_pkg::op_cmd_t             op_cmd,
  output ip2_pkg::static_cfg_t         static_cfg,
  output logic [ARRAY_DEPTH-1:0][15:0] cfg_array   // Scan chain data, word 0 shifted first
);

  localparam int AW = $clog2(ARRAY_DEPTH);

  logic [AW-1:0] wr_idx;                           // Array word selected by addr

  assign wr_idx = AW'(op_cmd.addr % ARRAY_DEPTH);  // Wraps past the array end

  // Static register, cleared so a read after reset gives zero
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      static_cfg <= '0;
    end else if (op_cmd.w_static) begin
      static_cfg <= op_cmd.data;
    end
  end

  // Array storage, low 16 bits of the write word
  always_ff @(posedge fw_axi_clk) begin
    if (op_cmd.w_array) begin
      cfg_array[wr_idx] <= op_cmd.data[15:0];
    end
  end

endmodule

`default_nettype wire

/* src/ip2_scan_test.sv */
// Test 1 FSM with execute check, phase and bit counters, scan-in shift register, pin drive
`timescale 1ns/1ps
`default_nettype none

module ip2_scan_test #(
  parameter int SCAN_BITS   = ip2_pkg::DEF_SCAN_BITS,
  parameter int ARRAY_DEPTH = ip2_pkg::DEF_ARRAY_DEPTH
) (
  input  logic                         fw_axi_clk,
  input  logic                         op_code_w_reset,
  input  ip2_pkg::op_cmd_t             op_cmd,
  input  ip2_pkg::static_cfg_t         static_cfg,
  input  logic [ARRAY_DEPTH-1:0][15:0] cfg_array,
  output ip2_pkg::pins_t               pins,
  output logic                         sample_en,   // Capture strobe, once per bit
  output logic                         shift_bit,   // Bit now on scan_in
  output logic                         loopback,    // Latched loopback flag
  output logic                         running,
  output logic                         done,
  output logic                         exec_error
);

  localparam int BW = $clog2(SCAN_BITS);

  typedef enum logic [2:0] {
    IDLE,
    DELAY,
    RESET_NOT,
    SHIFT,
    DONE
  } state_t;

  state_t               state;
  ip2_pkg::exec_cfg_t   exec_new;                  // Execute word as sent
  ip2_pkg::exec_cfg_t   exec_q;                    // Execute word of the current run
  logic [5:0]           period_q;                  // Bit period of the current run
  logic [5:0]           phase_cnt;                 // Cycle inside delay, reset or bit
  logic [BW-1:0]        bit_cnt;
  logic [SCAN_BITS-1:0] sreg;                      // Bit 0 drives scan_in
  logic                 start;
  logic                 cfg_bad;
  logic                 phase_last;

  // ---------------------------------------------------------------------
  // Execute check
  // ---------------------------------------------------------------------
  assign exec_new = op_cmd.data;
  assign cfg_bad  = (exec_new.test_number != ip2_pkg::TEST_SCAN) ||
                    (exec_new.test_delay < ip2_pkg::MIN_TEST_DELAY) ||
                    (exec_new.test_delay > static_cfg.bit_period) ||
                    (exec_new.test_sample >= static_cfg.bit_period);
  assign start      = op_cmd.w_execute && !running;    // Ignored during a run
  assign phase_last = (phase_cnt == period_q - 6'd1);

  // Error flag lives until the next execute or a status clear
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      exec_error <= 1'b0;
    end else if (start) begin
      exec_error <= cfg_bad;
    end else if (op_cmd.w_status_clear) begin
      exec_error <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------
  // FSM and counters
  // ---------------------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state     <= IDLE;
      phase_cnt <= '0;
      bit_cnt   <= '0;
    end else begin
      case (state)
        IDLE, DONE: begin
          phase_cnt <= '0;
          bit_cnt   <= '0;
          if (start) begin
            state <= cfg_bad ? IDLE : DELAY;       // Bad word keeps the test idle
          end else if (op_cmd.w_status_clear) begin
            state <= IDLE;                         // Drops done
          end
        end
        DELAY: begin
          if (phase_cnt == exec_q.test_delay - 6'd1) begin
            phase_cnt <= '0;
            state     <= exec_q.mask_reset_not ? SHIFT : RESET_NOT;
          end else begin
            phase_cnt <= phase_cnt + 6'd1;
          end
        end
        RESET_NOT: begin
          phase_cnt <= phase_last ? 6'd0 : phase_cnt + 6'd1;
          if (phase_last) begin
            state <= SHIFT;                        // One bit period of chip reset
          end
        end
        SHIFT: begin
          if (phase_last) begin
            phase_cnt <= '0;
            bit_cnt   <= bit_cnt + 1'b1;
            if (bit_cnt == BW'(SCAN_BITS - 1)) begin
              state <= DONE;
            end
          end else begin
            phase_cnt <= phase_cnt + 6'd1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Run settings and scan data, loaded on a good execute
  always_ff @(posedge fw_axi_clk) begin
    if (start && !cfg_bad) begin
      exec_q   <= exec_new;
      period_q <= static_cfg.bit_period;
      sreg     <= cfg_array[SCAN_BITS/16-1:0];     // Word 0 bit 0 goes out first
    end else if (state == SHIFT && phase_last) begin
      sreg <= {1'b0, sreg[SCAN_BITS-1:1]};
    end
  end

  // ---------------------------------------------------------------------
  // Outputs
  // ---------------------------------------------------------------------
  assign running   = (state == DELAY) || (state == RESET_NOT) || (state == SHIFT);
  assign done      = (state == DONE);
  assign shift_bit = sreg[0];
  assign loopback  = exec_q.loopback;
  assign sample_en = (state == SHIFT) && (phase_cnt == exec_q.test_sample);

  assign pins.reset_not       = (state != RESET_NOT);    // Active low pulse only
  assign pins.scan_in         = (state == SHIFT) && sreg[0];
  assign pins.scan_load       = 1'b0;                    // Chain stays in shift mode
  assign pins.super_pixel_sel = running && static_cfg.super_pixel_sel;

endmodule

`default_nettype wire

/* src/ip2_scan_capture.sv */
// Capture shift register fed by scan_out or by the looped back scan_in bit
`timescale 1ns/1ps
`default_nettype none

module ip2_scan_capture #(
  parameter int SCAN_BITS = ip2_pkg::DEF_SCAN_BITS
) (
  input  logic                 fw_axi_clk,
  input  logic                 op_code_w_reset,
  input  logic                 sample_en,         // One strobe per scan bit
  input  logic                 loopback_bit,      // Bit now driven on scan_in
  input  logic                 fw_scan_out,       // Chip scan chain output
  input  logic                 loopback,
  output logic [SCAN_BITS-1:0] capture            // First sampled bit ends in bit 0
);

  logic sample_bit;

  assign sample_bit = loopback ? loopback_bit : fw_scan_out;

  // Shifts in from the top and holds after the run for readout
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      capture <= '0;
    end else if (sample_en) begin
      capture <= {sample_bit, capture[SCAN_BITS-1:1]};
    end
  end

endmodule

`default_nettype wire

/* src/ip2_sw_readout.sv */
// Read data selection for static, array and capture reads, sticky status register
`timescale 1ns/1ps
`default_nettype none

module ip2_sw_readout #(
  parameter int SCAN_BITS   = ip2_pkg::DEF_SCAN_BITS,
  parameter int ARRAY_DEPTH = ip2_pkg::DEF_ARRAY_DEPTH
) (
  input  logic                         fw_axi_clk,
  input  logic                         op_code_w_reset,
  input  ip2_pkg::op_cmd_t             op_cmd,
  input  ip2_pkg::static_cfg_t         static_cfg,
  input  logic [ARRAY_DEPTH-1:0][15:0] cfg_array,
  input  logic [SCAN_BITS-1:0]         capture,
  input  logic                         done,
  input  logic                         exec_error,
  output logic [31:0]                  fw_read_data32,
  output logic [31:0]                  fw_read_status32
);

  localparam int AW     = $clog2(ARRAY_DEPTH);
  localparam int NWORDS = SCAN_BITS / 32;          // Capture words software can read

  logic [NWORDS-1:0][31:0] cap_words;
  logic [AW-1:0]           idx_lo;
  logic [AW-1:0]           idx_hi;
  logic [31:0]             status_q;

  assign cap_words = capture;
  assign idx_lo    = AW'(op_cmd.addr % ARRAY_DEPTH);
  assign idx_hi    = AW'((op_cmd.addr + 1) % ARRAY_DEPTH);   // Next word, wraps to 0

  // ---------------------------------------------------------------------
  // Read data, zero when no read strobe
  // ---------------------------------------------------------------------
  always_comb begin
    fw_read_data32 = '0;
    if (op_cmd.r_static) begin
      fw_read_data32 = {8'h00, static_cfg};
    end else if (op_cmd.r_array) begin
      fw_read_data32 = {cfg_array[idx_hi], cfg_array[idx_lo]};  // Pair, lower address low
    end else if (op_cmd.r_data && (op_cmd.addr < NWORDS)) begin
      fw_read_data32 = cap_words[op_cmd.addr];
    end
  end

  // ---------------------------------------------------------------------
  // Status, one sticky bit per op plus done and error
  // ---------------------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset || op_cmd.w_status_clear) begin
      status_q <= '0;
    end else begin
      if (op_cmd.w_static)  status_q[ip2_pkg::ST_W_STATIC] <= 1'b1;
      if (op_cmd.r_static)  status_q[ip2_pkg::ST_R_STATIC] <= 1'b1;
      if (op_cmd.w_array)   status_q[ip2_pkg::ST_W_ARRAY]  <= 1'b1;
      if (op_cmd.r_array)   status_q[ip2_pkg::ST_R_ARRAY]  <= 1'b1;
      if (op_cmd.r_data)    status_q[ip2_pkg::ST_R_DATA]   <= 1'b1;
      if (op_cmd.w_execute) status_q[ip2_pkg::ST_EXECUTE]  <= 1'b1;
      status_q[ip2_pkg::ST_DONE]  <= done;         // Follows the test
      status_q[ip2_pkg::ST_ERROR] <= exec_error;
    end
  end

  assign fw_read_status32 = status_q;

endmodule

`default_nettype wire

/* src/fw_ip2.sv */
// Test controller top level with op decode, config, scan test, capture and readout
`timescale 1ns/1ps
`default_nettype none

module fw_ip2 #(
  parameter int SCAN_BITS   = ip2_pkg::DEF_SCAN_BITS,
  parameter int ARRAY_DEPTH = ip2_pkg::DEF_ARRAY_DEPTH
) (
  input  logic        fw_axi_clk,
  input  logic        op_code_w_reset,
  // Software port
  input  logic        fw_dev_id_enable,
  input  logic        fw_op_code_w_static,
  input  logic        fw_op_code_r_static,
  input  logic        fw_op_code_w_array,
  input  logic        fw_op_code_r_array,
  input  logic        fw_op_code_r_data,
  input  logic        fw_op_code_w_status_clear,
  input  logic        fw_op_code_w_execute,
  input  logic [23:0] sw_write24_0,
  output logic [31:0] fw_read_data32,
  output logic [31:0] fw_read_status32,
  // Chip pins
  output logic        fw_reset_not,
  output logic        fw_scan_in,
  output logic        fw_scan_load,
  output logic        fw_super_pixel_sel,
  input  logic        fw_scan_out
);

  ip2_pkg::op_cmd_t             op_cmd;
  ip2_pkg::static_cfg_t         static_cfg;
  logic [ARRAY_DEPTH-1:0][15:0] cfg_array;
  ip2_pkg::pins_t               pins;
  logic                         sample_en;
  logic                         shift_bit;
  logic                         loopback;
  logic                         running;
  logic                         done;
  logic                         exec_error;
  logic [SCAN_BITS-1:0]         capture;

  // ---------------------------------------------------------------------
  // Blocks, ports named as the nets here
  // ---------------------------------------------------------------------
  ip2_op_decode op_decode_i (.*);

  ip2_cfg_regs #(
    .ARRAY_DEPTH (ARRAY_DEPTH)
  ) cfg_regs_i (.*);

  ip2_scan_test #(
    .SCAN_BITS   (SCAN_BITS),
    .ARRAY_DEPTH (ARRAY_DEPTH)
  ) scan_test_i (.*);

  ip2_scan_capture #(
    .SCAN_BITS (SCAN_BITS)
  ) scan_capture_i (
    .loopback_bit (shift_bit),                     // Looped back scan_in
    .*
  );

  ip2_sw_readout #(
    .SCAN_BITS   (SCAN_BITS),
    .ARRAY_DEPTH (ARRAY_DEPTH)
  ) sw_readout_i (.*);

  // Pin struct out to the chip
  assign fw_reset_not       = pins.reset_not;
  assign fw_scan_in         = pins.scan_in;
  assign fw_scan_load       = pins.scan_load;
  assign fw_super_pixel_sel = pins.super_pixel_sel;

endmodule

`default_nettype wire

/* bench/fw_ip2_properties.sv */
// Concurrent pin and state assertions for fw_ip2, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module fw_ip2_properties (
  input logic fw_axi_clk,
  input logic op_code_w_reset,
  input logic running,
  input logic done,
  input logic fw_scan_load,
  input logic fw_reset_not
);

  // Chain stays in shift mode through the whole run
  a_load_low_running : assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    running |-> !fw_scan_load)
    else $error("scan_load high while the test runs");

  // Chip reset only pulses inside a run
  a_reset_not_idle : assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    !running |-> fw_reset_not)
    else $error("reset_not low outside a run");

  a_done_not_running : assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    !(done && running))
    else $error("done and running high together");

endmodule

bind fw_ip2 fw_ip2_properties props_i (
  .fw_axi_clk      (fw_axi_clk),
  .op_code_w_reset (op_code_w_reset),
  .running         (running),
  .done            (done),
  .fw_scan_load    (fw_scan_load),
  .fw_reset_not    (fw_reset_not)
);

`default_nettype wire

/* bench/tb_fw_ip2.sv */
// Testbench for fw_ip2 with clock, reset, watchdog, directed test tasks and closing report
`timescale 1ns/1ps
`default_nettype none

module tb_fw_ip2;

  localparam int          SCAN_BITS   = ip2_pkg::DEF_SCAN_BITS;
  localparam int          ARRAY_DEPTH = ip2_pkg::DEF_ARRAY_DEPTH;
  localparam int          NWORDS      = SCAN_BITS / 32;       // Readable capture words
  localparam int          P_MAX       = 8;                    // Longest bit period used
  localparam longint      WATCHDOG_NS = longint'(4 * SCAN_BITS * P_MAX + 2000) * 10;
  localparam logic [31:0] SEED        = 32'h7475_63b7;

  // Strobe positions in op_strobe
  localparam int OP_W_STATIC  = 0;
  localparam int OP_R_STATIC  = 1;
  localparam int OP_W_ARRAY   = 2;
  localparam int OP_R_ARRAY   = 3;
  localparam int OP_R_DATA    = 4;
  localparam int OP_W_CLEAR   = 5;
  localparam int OP_W_EXECUTE = 6;

  logic        fw_axi_clk;
  logic        op_code_w_reset;
  logic        fw_dev_id_enable;
  logic [6:0]  op_strobe;
  logic [23:0] sw_write24_0;
  logic        fw_scan_out;
  logic [31:0] fw_read_data32;
  logic [31:0] fw_read_status32;
  logic        fw_reset_not;
  logic        fw_scan_in;
  logic        fw_scan_load;
  logic        fw_super_pixel_sel;

  logic [15:0] array_model [ARRAY_DEPTH];          // Expected array contents
  logic [23:0] static_model;                       // Expected static register
  int          errors;
  int          checks;
  int          reset_low_cnt = 0;                  // Cycles with reset_not low
  int          spx_cnt = 0;                        // Cycles with super_pixel_sel high
  int          scan_hi_cnt = 0;                    // Cycles with scan_in high

  fw_ip2 #(
    .SCAN_BITS   (SCAN_BITS),
    .ARRAY_DEPTH (ARRAY_DEPTH)
  ) dut_i (
    .fw_axi_clk                (fw_axi_clk),
    .op_code_w_reset           (op_code_w_reset),
    .fw_dev_id_enable          (fw_dev_id_enable),
    .fw_op_code_w_static       (op_strobe[OP_W_STATIC]),
    .fw_op_code_r_static       (op_strobe[OP_R_STATIC]),
    .fw_op_code_w_array        (op_strobe[OP_W_ARRAY]),
    .fw_op_code_r_array        (op_strobe[OP_R_ARRAY]),
    .fw_op_code_r_data         (op_strobe[OP_R_DATA]),
    .fw_op_code_w_status_clear (op_strobe[OP_W_CLEAR]),
    .fw_op_code_w_execute      (op_strobe[OP_W_EXECUTE]),
    .sw_write24_0              (sw_write24_0),
    .fw_read_data32            (fw_read_data32),
    .fw_read_status32          (fw_read_status32),
    .fw_reset_not              (fw_reset_not),
    .fw_scan_in                (fw_scan_in),
    .fw_scan_load              (fw_scan_load),
    .fw_super_pixel_sel        (fw_super_pixel_sel),
    .fw_scan_out               (fw_scan_out)
  );

  initial begin
    fw_axi_clk = 1'b0;
    forever #5 fw_axi_clk = ~fw_axi_clk;           // 100 MHz
  end

  // Pin activity counters, sampled before the edge updates
  always @(posedge fw_axi_clk) begin
    if (fw_reset_not === 1'b0) reset_low_cnt <= reset_low_cnt + 1;
    if (fw_super_pixel_sel === 1'b1) spx_cnt <= spx_cnt + 1;
    if (fw_scan_in === 1'b1) scan_hi_cnt <= scan_hi_cnt + 1;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, tests still running after %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Check failed at %0d ns: %s", $time, what);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge fw_axi_clk);
      #1;
    end
  endtask

  // One strobe cycle; on return the op sits in the command register
  task automatic send_op(input int op, input logic [23:0] word);
    op_strobe    = 7'b1 << op;
    sw_write24_0 = word;
    @(posedge fw_axi_clk);
    #1;
    op_strobe = '0;
  endtask

  task automatic read_op(input int op, input logic [7:0] addr, output logic [31:0] data);
    send_op(op, {addr, 16'h0000});
    data = fw_read_data32;                         // Combinational from the command
  endtask

  // Execute word, bit 23 mask, 16 loopback, 15:12 test, 11:6 sample, 5:0 delay
  function automatic logic [23:0] exec_word(input logic [5:0] delay, input logic [5:0] sample,
                                            input logic [3:0] number, input logic loop,
                                            input logic mask);
    return {mask, 6'h00, loop, number, sample, delay};
  endfunction

  task automatic write_static(input logic [23:0] word);
    send_op(OP_W_STATIC, word);
    static_model = word;
  endtask

  // Clear status, execute, then poll the done bit up to max_cycles
  task automatic run_exec(input logic [23:0] word, input int max_cycles, output bit done_seen);
    int n;
    send_op(OP_W_CLEAR, 24'h0);
    send_op(OP_W_EXECUTE, word);
    done_seen = 1'b0;
    n = 0;
    while (!done_seen && n < max_cycles) begin
      @(posedge fw_axi_clk);
      #1;
      done_seen = fw_read_status32[ip2_pkg::ST_DONE];
      n++;
    end
  endtask

  // ---------------------------------------------------------------------
  // Directed tests
  // ---------------------------------------------------------------------
  task automatic test_reset();
    logic [31:0] rd;
    check_eq("fw_read_status32", fw_read_status32, 32'h0);
    check_eq("pins {reset_not,scan_in,scan_load,super_pixel_sel}",
             {28'h0, fw_reset_not, fw_scan_in, fw_scan_load, fw_super_pixel_sel}, 32'h8);
    read_op(OP_R_STATIC, 8'h00, rd);
    check_eq("fw_read_data32 static", rd, 32'h0);
    static_model = 24'h0;
  endtask

  task automatic test_regs();
    logic [31:0] rd;
    logic [7:0]  addr;
    logic [15:0] val;
    send_op(OP_W_CLEAR, 24'h0);
    write_static(24'($urandom));
    read_op(OP_R_STATIC, 8'h00, rd);
    check_eq("fw_read_data32 static", rd, {8'h00, static_model});
    for (int a = 0; a < ARRAY_DEPTH; a++) begin
      addr = 8'(a) + 8'(ARRAY_DEPTH) * 8'($urandom_range(0, 3));   // Aliased addresses too
      val  = 16'($urandom);
      array_model[a] = val;
      send_op(OP_W_ARRAY, {addr, val});
    end
    repeat (8) begin                               // Overwrites at random places
      addr = 8'($urandom);
      val  = 16'($urandom);
      array_model[int'(addr) % ARRAY_DEPTH] = val;
      send_op(OP_W_ARRAY, {addr, val});
    end
    for (int a = 0; a <= ARRAY_DEPTH; a++) begin
      addr = (a < ARRAY_DEPTH) ? 8'(a) : 8'($urandom_range(ARRAY_DEPTH, 255));
      read_op(OP_R_ARRAY, addr, rd);
      check_eq("fw_read_data32 array", rd, {array_model[(int'(addr) + 1) % ARRAY_DEPTH],
                                            array_model[int'(addr) % ARRAY_DEPTH]});
    end
    idle_cycles(1);
    check_eq("fw_read_status32", fw_read_status32,
             (32'h1 << ip2_pkg::ST_W_STATIC) | (32'h1 << ip2_pkg::ST_R_STATIC) |
             (32'h1 << ip2_pkg::ST_W_ARRAY) | (32'h1 << ip2_pkg::ST_R_ARRAY));
    send_op(OP_W_CLEAR, 24'h0);
    idle_cycles(1);
    check_eq("fw_read_status32 after clear", fw_read_status32, 32'h0);
  endtask

  task automatic test_loopback();
    logic [31:0] rd;
    bit          got_done;
    int          low_before;
    int          spx_before;
    int          scan_before;
    int          ones;
    write_static({11'h000, 1'b1, 6'h00, 6'd4});    // Period 4, super pixel on
    low_before  = reset_low_cnt;
    spx_before  = spx_cnt;
    scan_before = scan_hi_cnt;
    ones = 0;
    for (int w = 0; w < SCAN_BITS / 16; w++) begin
      ones += $countones(array_model[w]);          // Ones shifted out of the array
    end
    run_exec(exec_word(6'd3, 6'd1, 4'd1, 1'b1, 1'b0), SCAN_BITS * 4 + 100, got_done);
    check_true(got_done, "done not set after a loopback run");
    check_true(reset_low_cnt - low_before == 4, "reset_not low pulse is not one bit period");
    check_true(spx_cnt > spx_before, "super_pixel_sel not driven during the run");
    // Each scan bit stays on the pin for one bit period
    check_eq("fw_scan_in high cycles", 32'(scan_hi_cnt - scan_before), 32'(4 * ones));
    check_eq("pins {reset_not,scan_in,scan_load,super_pixel_sel}",
             {28'h0, fw_reset_not, fw_scan_in, fw_scan_load, fw_super_pixel_sel}, 32'h8);
    for (int w = 0; w < NWORDS; w++) begin
      read_op(OP_R_DATA, 8'(w), rd);
      check_eq("fw_read_data32 capture", rd, {array_model[2 * w + 1], array_model[2 * w]});
    end
    read_op(OP_R_DATA, 8'(NWORDS), rd);            // First word past the capture
    check_eq("fw_read_data32 out of range", rd, 32'h0);
  endtask

  task automatic test_scan_out();
    logic [31:0] rd;
    bit          got_done;
    int          low_before;
    fw_scan_out = 1'b1;
    write_static({11'h000, 1'b0, 6'h00, 6'(P_MAX)});
    low_before = reset_low_cnt;
    // Delay equal to the period and the last sample phase, both at their limits
    run_exec(exec_word(6'(P_MAX), 6'(P_MAX - 1), 4'd1, 1'b0, 1'b1),
             SCAN_BITS * P_MAX + 100, got_done);
    check_true(got_done, "done not set after a scan_out run");
    check_true(reset_low_cnt == low_before, "reset_not pulsed although masked");
    for (int w = 0; w < NWORDS; w++) begin
      read_op(OP_R_DATA, 8'(w), rd);
      check_eq("fw_read_data32 capture", rd, 32'hffff_ffff);
    end
    fw_scan_out = 1'b0;
  endtask

  task automatic test_bad_exec();
    logic [23:0] bad [2];
    bit          got_done;
    int          low_before;
    bad[0] = exec_word(6'd2, 6'd1, 4'd1, 1'b0, 1'b0);   // Delay below minimum
    bad[1] = exec_word(6'd3, 6'd1, 4'd2, 1'b0, 1'b0);   // Dropped test number
    foreach (bad[i]) begin
      low_before = reset_low_cnt;
      run_exec(bad[i], 1000, got_done);
      check_true(!got_done, "done set after a rejected execute");
      check_eq("fw_read_status32", fw_read_status32,
               (32'h1 << ip2_pkg::ST_EXECUTE) | (32'h1 << ip2_pkg::ST_ERROR));
      check_true(reset_low_cnt == low_before, "reset_not went low after a rejected execute");
    end
  endtask

  task automatic test_disabled();
    logic [31:0] rd;
    send_op(OP_W_CLEAR, 24'h0);
    idle_cycles(1);
    fw_dev_id_enable = 1'b0;                       // Another board addressed
    send_op(OP_W_STATIC, 24'($urandom));
    send_op(OP_W_ARRAY, {8'h00, 16'($urandom)});
    fw_dev_id_enable = 1'b1;
    idle_cycles(1);
    check_eq("fw_read_status32", fw_read_status32, 32'h0);
    read_op(OP_R_STATIC, 8'h00, rd);
    check_eq("fw_read_data32 static", rd, {8'h00, static_model});
    read_op(OP_R_ARRAY, 8'h00, rd);
    check_eq("fw_read_data32 array", rd, {array_model[1], array_model[0]});
  endtask

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    op_code_w_reset  = 1'b1;
    fw_dev_id_enable = 1'b1;
    op_strobe        = '0;
    sw_write24_0     = '0;
    fw_scan_out      = 1'b0;
    errors           = 0;
    checks           = 0;
    repeat (5) @(posedge fw_axi_clk);
    #1;
    op_code_w_reset = 1'b0;
    idle_cycles(1);
    test_reset();
    test_regs();
    test_loopback();
    test_scan_out();
    test_bad_exec();
    test_disabled();
    $display("Checks run %0d, checks failed %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
src/ip2_pkg.sv
src/ip2_op_decode.sv
src/ip2_cfg_regs.sv
src/ip2_scan_test.sv
src/ip2_scan_capture.sv
src/ip2_sw_readout.sv
src/fw_ip2.sv
bench/fw_ip2_properties.sv
bench/tb_fw_ip2.sv

/* run.sh */
#!/usr/bin/env bash
# Build the fw_ip2 testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fw_ip2 --Mdir obj_dir -o sim_tb -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/sim_tb 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
